// File: filelist.f
source/fusion_pkg.sv
source/bitbrick.sv
source/brick_sign_ctrl.sv
source/fusion_reducer.sv
source/fusion_accumulator.sv
source/fusion_unit.sv
verif/tb_fusion_unit.sv

// File: Bender.yml
package:
  name: fusion_unit

sources:
  - source/fusion_pkg.sv
  - source/bitbrick.sv
  - source/brick_sign_ctrl.sv
  - source/fusion_reducer.sv
  - source/fusion_accumulator.sv
  - source/fusion_unit.sv
  - target: test
    files:
      - verif/tb_fusion_unit.sv

// File: verif/tb_fusion_unit.sv
`timescale 1ns/1ps

module tb_fusion_unit import fusion_pkg::*; ();

    localparam int SUM_W        = 20;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_RANDOM   = 200;

    // one stimulus row applied for one clock cycle
    typedef struct packed {
        mode_t                mode;
        logic                 sx;
        logic                 sy;
        logic [OPERAND_W-1:0] x;
        logic [OPERAND_W-1:0] y;
        logic                 en;
    } entry_t;

    logic                 clk;
    logic                 nrst;
    logic [OPERAND_W-1:0] x;
    logic [OPERAND_W-1:0] y;
    logic                 sx;
    logic                 sy;
    logic                 en;
    mode_t                mode;
    logic [PRODUCT_W-1:0] product;
    logic [SUM_W-1:0]     sum;

    entry_t           entries [$];
    logic [31:0]      lfsr_state;
    logic [SUM_W-1:0] exp_sum;
    mode_t            prev_mode;
    int               n_checks;
    int               n_errors;
    bit               table_ready = 1'b0;

    fusion_unit #(
        .SUM_W (SUM_W)
    ) UUT (
        .clk     (clk),
        .nrst    (nrst),
        .x       (x),
        .y       (y),
        .sx      (sx),
        .sy      (sy),
        .en      (en),
        .mode    (mode),
        .product (product),
        .sum     (sum)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // w-bit field at lsb read as two's complement when is_signed is set
    function automatic int field_val(logic [31:0] v, int lsb, int w, logic is_signed);
        int raw;
        raw = (int'(v) >> lsb) & ((1 << w) - 1);
        if (is_signed && raw[w-1]) begin
            raw = raw - (1 << w);
        end
        return raw;
    endfunction

    // sum of all cross products at the operand width of the mode
    function automatic logic [PRODUCT_W-1:0] ref_product(entry_t t);
        int acc;
        int op_w;
        int res_w;
        acc = 0;
        case (t.mode)
            MODE_8X8: op_w = 8;
            MODE_4X4: op_w = 4;
            MODE_2X2: op_w = 2;
            default:  op_w = 0;
        endcase
        // result field width of each mode
        case (t.mode)
            MODE_8X8: res_w = 16;
            MODE_4X4: res_w = 10;
            MODE_2X2: res_w = 8;
            default:  res_w = 0;
        endcase
        if (op_w == 0) begin
            return '0;
        end
        for (int i = 0; i < OPERAND_W; i += op_w) begin
            for (int j = 0; j < OPERAND_W; j += op_w) begin
                acc += field_val(32'(t.x), i, op_w, t.sx) * field_val(32'(t.y), j, op_w, t.sy);
            end
        end
        // wrap to the field so the upper product bits stay clear
        return PRODUCT_W'(acc & ((1 << res_w) - 1));
    endfunction

    // predicts the sum after the next rising edge
    task automatic accumulate_model(input entry_t t, input logic [PRODUCT_W-1:0] p);
        int fw;
        int aw;
        int acc;
        if (t.mode != prev_mode) begin
            exp_sum = '0;
        end else if (t.en) begin
            case (t.mode)
                MODE_8X8: fw = 16;
                MODE_4X4: fw = 10;
                MODE_2X2: fw = 8;
                default:  fw = 0;
            endcase
            case (t.mode)
                MODE_8X8: aw = 20;
                MODE_4X4: aw = 12;
                MODE_2X2: aw = 10;
                default:  aw = 0;
            endcase
            if (fw == 0) begin
                exp_sum = '0;
            end else begin
                // product field always taken as signed
                acc = (int'(exp_sum) & ((1 << aw) - 1)) + field_val(32'(p), 0, fw, 1'b1);
                exp_sum = SUM_W'(acc & ((1 << aw) - 1));
            end
        end
        prev_mode = t.mode;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////////////////////

    function automatic entry_t make_entry(mode_t m, logic s_x, logic s_y,
                                          logic [7:0] a, logic [7:0] b, logic e);
        entry_t t;
        t.mode = m;
        t.sx   = s_x;
        t.sy   = s_y;
        t.x    = a;
        t.y    = b;
        t.en   = e;
        return t;
    endfunction

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    task automatic take_bits(input int n, output logic [31:0] r);
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
    endtask

    task automatic build_table();
        logic [31:0] r;
        mode_t       cur_mode;
        // first cycle after reset clears even with en high
        entries.push_back(make_entry(MODE_8X8, 1'b0, 1'b0, 8'h03, 8'h05, 1'b1));
        // 8x8 corners in all four sign combinations
        entries.push_back(make_entry(MODE_8X8, 1'b0, 1'b0, 8'hFF, 8'hFF, 1'b1));
        entries.push_back(make_entry(MODE_8X8, 1'b1, 1'b1, 8'h80, 8'h80, 1'b1));
        entries.push_back(make_entry(MODE_8X8, 1'b1, 1'b0, 8'h80, 8'hFF, 1'b1));
        entries.push_back(make_entry(MODE_8X8, 1'b0, 1'b1, 8'hFF, 8'h80, 1'b1));
        entries.push_back(make_entry(MODE_8X8, 1'b1, 1'b1, 8'hFF, 8'hFF, 1'b1));
        entries.push_back(make_entry(MODE_8X8, 1'b1, 1'b1, 8'h7F, 8'h80, 1'b1));
        // en low holds
        entries.push_back(make_entry(MODE_8X8, 1'b0, 1'b0, 8'h12, 8'h34, 1'b0));
        entries.push_back(make_entry(MODE_8X8, 1'b1, 1'b0, 8'hA5, 8'h3C, 1'b1));
        // switch to 4x4 so the first cycle clears
        entries.push_back(make_entry(MODE_4X4, 1'b0, 1'b0, 8'hFF, 8'hFF, 1'b1));
        entries.push_back(make_entry(MODE_4X4, 1'b0, 1'b0, 8'hFF, 8'hFF, 1'b1));
        entries.push_back(make_entry(MODE_4X4, 1'b1, 1'b1, 8'h88, 8'h88, 1'b1));
        entries.push_back(make_entry(MODE_4X4, 1'b1, 1'b0, 8'h8F, 8'h7A, 1'b1));
        entries.push_back(make_entry(MODE_4X4, 1'b0, 1'b1, 8'h3C, 8'hC3, 1'b1));
        entries.push_back(make_entry(MODE_4X4, 1'b1, 1'b1, 8'h77, 8'h88, 1'b0));
        entries.push_back(make_entry(MODE_4X4, 1'b1, 1'b1, 8'h77, 8'h88, 1'b1));
        // 2x2 sums sixteen small products
        entries.push_back(make_entry(MODE_2X2, 1'b0, 1'b0, 8'hFF, 8'hFF, 1'b1));
        entries.push_back(make_entry(MODE_2X2, 1'b0, 1'b0, 8'hFF, 8'hFF, 1'b1));
        entries.push_back(make_entry(MODE_2X2, 1'b1, 1'b1, 8'hAA, 8'hAA, 1'b1));
        entries.push_back(make_entry(MODE_2X2, 1'b1, 1'b0, 8'h55, 8'hAA, 1'b1));
        entries.push_back(make_entry(MODE_2X2, 1'b0, 1'b1, 8'hFF, 8'h5A, 1'b0));
        entries.push_back(make_entry(MODE_2X2, 1'b1, 1'b1, 8'h96, 8'h69, 1'b1));
        // invalid codes give a zero product and clear on en
        entries.push_back(make_entry(4'd7, 1'b1, 1'b1, 8'hFF, 8'hFF, 1'b1));
        entries.push_back(make_entry(4'd7, 1'b1, 1'b1, 8'hFF, 8'hFF, 1'b1));
        entries.push_back(make_entry(MODE_8X8, 1'b0, 1'b0, 8'h40, 8'h40, 1'b1));
        entries.push_back(make_entry(MODE_8X8, 1'b0, 1'b0, 8'h40, 8'h40, 1'b1));
        entries.push_back(make_entry(MODE_RESET, 1'b0, 1'b1, 8'h81, 8'h18, 1'b1));
        entries.push_back(make_entry(MODE_RESET, 1'b0, 1'b1, 8'h81, 8'h18, 1'b1));
        // random rows hold the mode mostly so the sum can build up
        cur_mode = MODE_8X8;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            take_bits(2, r);
            if (r[1:0] == 2'b00) begin
                take_bits(2, r);
                cur_mode = {2'b00, r[1:0]};
            end
            take_bits(19, r);
            entries.push_back(make_entry(cur_mode, r[18], r[17], r[16:9], r[8:1], r[0]));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_product(input int idx, input logic [PRODUCT_W-1:0] exp_p);
        n_checks++;
        if (product !== exp_p) begin
            n_errors++;
            $display("ERR %0t entry %0d product exp %h got %h", $time, idx, exp_p, product);
        end
    endtask

    task automatic check_sum(input int idx);
        n_checks++;
        if (sum !== exp_sum) begin
            n_errors++;
            $display("ERR %0t entry %0d sum exp %h got %h", $time, idx, exp_sum, sum);
        end
    endtask

    initial begin
        entry_t               cur;
        logic [PRODUCT_W-1:0] exp_p;
        nrst       = 1'b0;
        x          = '0;
        y          = '0;
        sx         = 1'b0;
        sy         = 1'b0;
        en         = 1'b0;
        mode       = MODE_2X2;
        exp_sum    = '0;
        prev_mode  = MODE_RESET;
        n_checks   = 0;
        n_errors   = 0;
        lfsr_state = 32'h6099e91b;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        nrst = 1'b1;
        for (int i = 0; i < entries.size(); i++) begin
            // sum reflects the row of the previous cycle
            check_sum(i);
            cur  = entries[i];
            mode = cur.mode;
            sx   = cur.sx;
            sy   = cur.sy;
            x    = cur.x;
            y    = cur.y;
            en   = cur.en;
            exp_p = ref_product(cur);
            #4;
            check_product(i, exp_p);
            accumulate_model(cur, exp_p);
            @(posedge clk);
            #1;
        end
        check_sum(entries.size());
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog at twice the expected run time
    initial begin
        wait (table_ready);
        #((entries.size() + RESET_CYCLES) * CLK_PERIOD * 2);
        $display("timeout, run did not finish %0d entries in time", entries.size());
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: source/fusion_unit.sv
`timescale 1ns/1ps

module fusion_unit import fusion_pkg::*; #(
    parameter int SUM_W = SUM_W_DEFAULT
) (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic [OPERAND_W-1:0] x,
    input  logic [OPERAND_W-1:0] y,
    input  logic                 sx,
    input  logic                 sy,
    input  logic                 en,
    input  mode_t                mode,
    output logic [PRODUCT_W-1:0] product,
    output logic [SUM_W-1:0]     sum
);

    // nibble width, two pieces per nibble
    localparam int NIB_W = 2 * BRICK_IN_W;

    logic [BRICK_IN_W-1:0] bx_piece [NUM_BRICKS];
    logic [BRICK_IN_W-1:0] by_piece [NUM_BRICKS];
    logic [NUM_BRICKS-1:0] bx_signed;
    logic [NUM_BRICKS-1:0] by_signed;
    brick_prod_t           brick_prod [NUM_BRICKS];

    // per-brick sign flags from mode and operand signs
    brick_sign_ctrl u_sign_ctrl (
        .mode      (mode),
        .sx        (sx),
        .sy        (sy),
        .bx_signed (bx_signed),
        .by_signed (by_signed)
    );

    ////////////////////////////////////////////////////////////////////////////
    // operand slicing and brick array
    ////////////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < NUM_BRICKS; k++) begin : g_brick
        // block k/4 picks the nibbles in hh, hl, lh, ll order
        // position k%4 picks the halves in the same order
        localparam int X_LSB = NIB_W * (1 - (k / 4) / 2) + BRICK_IN_W * (1 - (k % 4) / 2);
        localparam int Y_LSB = NIB_W * (1 - (k / 4) % 2) + BRICK_IN_W * (1 - (k % 4) % 2);

        assign bx_piece[k] = x[X_LSB +: BRICK_IN_W];
        assign by_piece[k] = y[Y_LSB +: BRICK_IN_W];

        bitbrick u_brick (
            .x        (bx_piece[k]),
            .y        (by_piece[k]),
            .x_signed (bx_signed[k]),
            .y_signed (by_signed[k]),
            .p        (brick_prod[k])
        );
    end

    // fuse the bricks for the current precision
    fusion_reducer u_reducer (
        .mode       (mode),
        .sx         (sx),
        .sy         (sy),
        .brick_prod (brick_prod),
        .product    (product)
    );

    fusion_accumulator #(
        .SUM_W (SUM_W)
    ) u_accumulator (
        .clk     (clk),
        .nrst    (nrst),
        .mode    (mode),
        .en      (en),
        .product (product),
        .sum     (sum)
    );

endmodule

// File: source/fusion_accumulator.sv
`timescale 1ns/1ps

module fusion_accumulator import fusion_pkg::*; #(
    parameter int SUM_W = SUM_W_DEFAULT
) (
    input  logic                 clk,
    input  logic                 nrst,
    input  mode_t                mode,
    input  logic                 en,
    input  logic [PRODUCT_W-1:0] product,
    output logic [SUM_W-1:0]     sum
);

    // accumulator fields per mode and the product field they take
    localparam int ACC4_W = 12;
    localparam int P4_W   = 10;
    localparam int ACC2_W = 10;
    localparam int P2_W   = 8;

    if (SUM_W < SUM_W_DEFAULT) begin : g_width_check
        $error("SUM_W must be at least %0d", SUM_W_DEFAULT);
    end

    mode_t             mode_q;
    logic              mode_change;
    logic [SUM_W-1:0]  acc8_next;
    logic [ACC4_W-1:0] acc4_next;
    logic [ACC2_W-1:0] acc2_next;

    ////////////////////////////////////////////////////////////////////////////
    // mode history
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!nrst) begin
            mode_q <= MODE_RESET;
        end else begin
            mode_q <= mode;
        end
    end

    assign mode_change = (mode != mode_q);

    ////////////////////////////////////////////////////////////////////////////
    // running sum
    ////////////////////////////////////////////////////////////////////////////

    // field adds, each sign extends from the top of its product field
    assign acc8_next = sum + {{(SUM_W-PRODUCT_W){product[PRODUCT_W-1]}}, product};
    assign acc4_next = sum[ACC4_W-1:0] + {{(ACC4_W-P4_W){product[P4_W-1]}}, product[P4_W-1:0]};
    assign acc2_next = sum[ACC2_W-1:0] + {{(ACC2_W-P2_W){product[P2_W-1]}}, product[P2_W-1:0]};

    always_ff @(posedge clk) begin
        if (!nrst) begin
            sum <= '0;
        end else if (mode_change) begin
            // new precision starts from zero, en does not matter
            sum <= '0;
        end else if (en) begin
            case (mode)
                MODE_8X8: sum <= acc8_next;
                // narrow fields zero fill the rest
                MODE_4X4: sum <= SUM_W'(acc4_next);
                MODE_2X2: sum <= SUM_W'(acc2_next);
                default:  sum <= '0;
            endcase
        end
    end

    // a mode switch leaves an empty sum one edge later
    assert property (@(posedge clk) disable iff (!nrst) mode_change |=> (sum == '0))
        else $error("sum not cleared after mode change");

    // after a 2x2 cycle only the 10-bit field can be set
    assert property (@(posedge clk) disable iff (!nrst)
        (mode_q == MODE_2X2) |-> (sum[SUM_W-1:ACC2_W] == '0))
        else $error("2x2 sum has upper bits set %h", sum);

endmodule

// File: source/fusion_reducer.sv
`timescale 1ns/1ps

module fusion_reducer import fusion_pkg::*; (
    input  mode_t                mode,
    input  logic                 sx,
    input  logic                 sy,
    input  brick_prod_t          brick_prod [NUM_BRICKS],
    output logic [PRODUCT_W-1:0] product
);

    // 4x4 block product and the per-mode result fields
    localparam int BLK_W   = 8;
    localparam int NUM_BLK = NUM_BRICKS / 4;
    localparam int CROSS_W = 12;
    localparam int SUM4_W  = 10;
    localparam int SUM2_W  = 8;

    logic [BLK_W-1:0]   blk_prod [NUM_BLK];
    logic [CROSS_W-1:0] cross_sum;
    logic [SUM4_W-1:0]  sum4;
    logic [SUM2_W-1:0]  sum2;
    logic               blk_ext;

    ////////////////////////////////////////////////////////////////////////////
    // block merge, four bricks into one 4x4 product
    ////////////////////////////////////////////////////////////////////////////

    for (genvar b = 0; b < NUM_BLK; b++) begin : g_blk
        brick_prod_t         hh;
        brick_prod_t         hl;
        brick_prod_t         lh;
        brick_prod_t         ll;
        logic [BRICK_P_W:0]  mid;

        assign hh = brick_prod[4*b];
        assign hl = brick_prod[4*b+1];
        assign lh = brick_prod[4*b+2];
        assign ll = brick_prod[4*b+3];

        // middle terms share weight 4, sign extended before the add
        assign mid = {hl[BRICK_P_W-1], hl} + {lh[BRICK_P_W-1], lh};

        // low brick is unsigned here, so its top bit is always 0
        // hh sits at weight 16 right above it
        assign blk_prod[b] = BLK_W'({hh, ll[BRICK_P_W-2:0]}) + BLK_W'({mid, 2'b00});
    end

    ////////////////////////////////////////////////////////////////////////////
    // mode select
    ////////////////////////////////////////////////////////////////////////////

    // a nibble product is two's complement once either side is signed
    assign blk_ext = sx | sy;

    always_comb begin
        // cross blocks x-high*y-low and x-low*y-high, sign set by the high side
        cross_sum = {{(CROSS_W-BLK_W){blk_prod[1][BLK_W-1] & sx}}, blk_prod[1]}
                  + {{(CROSS_W-BLK_W){blk_prod[2][BLK_W-1] & sy}}, blk_prod[2]};

        // sum of the four nibble products
        sum4 = '0;
        for (int b = 0; b < NUM_BLK; b++) begin
            sum4 = sum4 + {{(SUM4_W-BLK_W){blk_prod[b][BLK_W-1] & blk_ext}}, blk_prod[b]};
        end

        // sum of the sixteen brick products
        // an unsigned brick tops out at 9 so the sign bit is safe to copy
        sum2 = '0;
        for (int k = 0; k < NUM_BRICKS; k++) begin
            sum2 = sum2 + {{(SUM2_W-BRICK_P_W){brick_prod[k][BRICK_P_W-1]}}, brick_prod[k]};
        end

        case (mode)
            MODE_8X8: begin
                // high block at weight 256, low block at 1, crosses at 16
                product = {blk_prod[0], blk_prod[NUM_BLK-1]} + {cross_sum, 4'b0000};
            end
            MODE_4X4: begin
                product = {{(PRODUCT_W-SUM4_W){1'b0}}, sum4};
            end
            MODE_2X2: begin
                product = {{(PRODUCT_W-SUM2_W){1'b0}}, sum2};
            end
            default: begin
                product = '0;
            end
        endcase
    end

    // the narrow modes leave the top of the product clear
    always_comb begin
        if (mode == MODE_4X4) begin
            assert final (product[PRODUCT_W-1:SUM4_W] == '0)
                else $error("4x4 product has upper bits set %h", product);
        end
        if (mode == MODE_2X2) begin
            assert final (product[PRODUCT_W-1:SUM2_W] == '0)
                else $error("2x2 product has upper bits set %h", product);
        end
    end

endmodule

// File: source/brick_sign_ctrl.sv
`timescale 1ns/1ps

module brick_sign_ctrl import fusion_pkg::*; (
    input  mode_t                 mode,
    input  logic                  sx,
    input  logic                  sy,
    output logic [NUM_BRICKS-1:0] bx_signed,
    output logic [NUM_BRICKS-1:0] by_signed
);

    ////////////////////////////////////////////////////////////////////////////
    // constant masks of the bricks that see a top piece
    ////////////////////////////////////////////////////////////////////////////

    // block k/4 selects the nibbles, position k%4 selects the halves
    // x walks the high index bit, y the low one
    function automatic logic [NUM_BRICKS-1:0] top_mask(input bit for_y, input bit whole_word);
        logic [NUM_BRICKS-1:0] m;
        int blk_sel;
        int pos_sel;
        for (int k = 0; k < NUM_BRICKS; k++) begin
            blk_sel = for_y ? (k / 4) % 2 : (k / 4) / 2;
            pos_sel = for_y ? (k % 4) % 2 : (k % 4) / 2;
            // high half of the nibble, and the high nibble when the operand is a byte
            m[k] = (pos_sel == 0) && (!whole_word || blk_sel == 0);
        end
        return m;
    endfunction

    localparam logic [NUM_BRICKS-1:0] X_TOP_8X8 = top_mask(1'b0, 1'b1);
    localparam logic [NUM_BRICKS-1:0] Y_TOP_8X8 = top_mask(1'b1, 1'b1);
    localparam logic [NUM_BRICKS-1:0] X_TOP_4X4 = top_mask(1'b0, 1'b0);
    localparam logic [NUM_BRICKS-1:0] Y_TOP_4X4 = top_mask(1'b1, 1'b0);

    ////////////////////////////////////////////////////////////////////////////
    // flag select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (mode)
            MODE_8X8: begin
                // only the msb piece of each byte
                bx_signed = {NUM_BRICKS{sx}} & X_TOP_8X8;
                by_signed = {NUM_BRICKS{sy}} & Y_TOP_8X8;
            end
            MODE_4X4: begin
                // msb piece of every nibble
                bx_signed = {NUM_BRICKS{sx}} & X_TOP_4X4;
                by_signed = {NUM_BRICKS{sy}} & Y_TOP_4X4;
            end
            MODE_2X2: begin
                // each piece is an operand of its own
                bx_signed = {NUM_BRICKS{sx}};
                by_signed = {NUM_BRICKS{sy}};
            end
            default: begin
                bx_signed = '0;
                by_signed = '0;
            end
        endcase
    end

    // unknown mode codes must leave every brick unsigned
    always_comb begin
        if (!(mode inside {MODE_2X2, MODE_4X4, MODE_8X8})) begin
            assert final (bx_signed == '0 && by_signed == '0)
                else $error("sign flags set for invalid mode %0d", mode);
        end
    end

endmodule

// File: source/bitbrick.sv
`timescale 1ns/1ps

module bitbrick import fusion_pkg::*; (
    input  logic [BRICK_IN_W-1:0] x,
    input  logic [BRICK_IN_W-1:0] y,
    input  logic                  x_signed,
    input  logic                  y_signed,
    output brick_prod_t           p
);

    // full adder cell giving carry and sum
    function automatic logic [1:0] fa(input logic a, input logic b, input logic c);
        fa = {(a & b) | (a & c) | (b & c), a ^ b ^ c};
    endfunction

    // half adder cell giving carry and sum
    function automatic logic [1:0] ha(input logic a, input logic b);
        ha = {a & b, a ^ b};
    endfunction

    logic [2:0] xi;
    logic [2:0] yi;
    logic [2:0] pp0;
    logic [2:0] pp1;
    logic [2:0] pp2;
    logic [1:0] ha1;
    logic [1:0] fa2;
    logic [1:0] ha2;
    logic [1:0] fa3a;
    logic [1:0] fa3b;

    // 3-bit operands, top bit is the sign copy or a zero
    assign xi = {x_signed & x[1], x};
    assign yi = {y_signed & y[1], y};

    // baugh-wooley rows, terms with exactly one sign bit are inverted
    assign pp0 = {~(xi[2] & yi[0]), xi[1] & yi[0], xi[0] & yi[0]};
    assign pp1 = {~(xi[2] & yi[1]), xi[1] & yi[1], xi[0] & yi[1]};
    assign pp2 = {xi[2] & yi[2], ~(xi[1] & yi[2]), ~(xi[0] & yi[2])};

    // column 1
    assign ha1 = ha(pp0[1], pp1[0]);
    // column 2
    assign fa2 = fa(pp1[1], pp2[0], ha1[1]);
    assign ha2 = ha(pp0[2], fa2[0]);
    // column 3 takes the correction one
    assign fa3a = fa(pp1[2], pp2[1], fa2[1]);
    assign fa3b = fa(fa3a[0], ha2[1], 1'b1);

    // column 4 is the top bit, carries out of it are dropped
    assign p = {pp2[2] ^ fa3a[1] ^ fa3b[1], fa3b[0], ha2[0], ha1[0], pp0[0]};

endmodule

// File: source/fusion_pkg.sv
package fusion_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // precision modes
    ////////////////////////////////////////////////////////////////////////////

    localparam int MODE_W = 4;

    typedef logic [MODE_W-1:0] mode_t;

    // sum-together precisions
    localparam mode_t MODE_2X2 = 4'd0;
    localparam mode_t MODE_4X4 = 4'd1;
    localparam mode_t MODE_8X8 = 4'd2;

    // matches no valid mode so the first cycle after reset clears the sum
    localparam mode_t MODE_RESET = 4'd15;

    ////////////////////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////////////////////

    // full operand width on each side
    localparam int OPERAND_W = 8;

    // one brick multiplies a 2-bit piece of x by a 2-bit piece of y
    localparam int BRICK_IN_W = 2;
    localparam int BRICK_P_W  = 5;
    localparam int NUM_BRICKS = 16;

    // brick product, two's complement
    typedef logic [BRICK_P_W-1:0] brick_prod_t;

    // fused product and default accumulator width
    localparam int PRODUCT_W     = 16;
    localparam int SUM_W_DEFAULT = 20;

endpackage
